//--- usb_rx_pkg.sv
/*
 * Shared definitions for the full-speed USB receive path: recovered line
 * states, packet identifiers, field types and the CRC generator constants.
 */
package usb_rx_pkg;

  // line states recovered from the D+/D- pair, bit 2 marks a transition
  typedef enum logic [2:0] {
    SE0 = 3'b000,
    DK  = 3'b001,
    DJ  = 3'b010,
    DT  = 3'b100
  } line_state_e;

  // packet identifiers handled by the receiver, sent on the wire lsb first
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010
  } usb_pid_e;

  localparam int unsigned PidW      = 4;
  localparam int unsigned AddrW     = 7;
  localparam int unsigned EndpW     = 4;
  localparam int unsigned ByteW     = 8;
  localparam int unsigned LineHistW = 12;

  typedef logic [PidW-1:0]  pid_t;
  typedef logic [AddrW-1:0] usb_addr_t;
  typedef logic [EndpW-1:0] usb_endp_t;
  typedef logic [ByteW-1:0] usb_byte_t;

  // both CRC registers start from all ones at the beginning of a packet
  localparam logic [4:0]  Crc5Init      = 5'b11111;
  localparam logic [15:0] Crc16Init     = 16'hFFFF;
  localparam logic [4:0]  Crc5Poly      = 5'b00101;
  localparam logic [15:0] Crc16Poly     = 16'h8005;
  localparam logic [4:0]  Crc5Residual  = 5'b01100;
  localparam logic [15:0] Crc16Residual = 16'h800D;

  // last six sync symbols K J K J K K, oldest symbol in the top two bits
  localparam logic [LineHistW-1:0] SyncPattern = 12'b01_10_01_10_01_01;
  // line history after reset holds nothing but K symbols
  localparam logic [LineHistW-1:0] HistAllK    = 12'b01_01_01_01_01_01;

endpackage

//--- usb_rx_bit_if.sv
/*
 * Decoded bit stream with packet framing, from the framer to the decoder.
 */
`timescale 1ns/1ns

interface usb_rx_bit_if;

  // one pulse per unstuffed data bit
  logic bit_valid;
  // bit value, only looked at while bit_valid is high
  logic bit_data;
  // pulse as sync completes and the PID begins
  logic pkt_start;
  // pulse as the packet closes on EOP or a stuffing error
  logic pkt_end;
  // sticky stuffing error for the current packet
  logic stuff_err;

  modport framer (
    output bit_valid, bit_data, pkt_start, pkt_end, stuff_err
  );

  modport decoder (
    input bit_valid, bit_data, pkt_start, pkt_end, stuff_err
  );

endinterface

//--- usb_line_recovery.sv
/*
 * Line state and bit clock recovery. Samples D+/D- at four times the bit
 * rate, guards every change with a transition cycle and tracks bit phase.
 */
`timescale 1ns/1ns

module usb_line_recovery (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    usb_dp_i,
  input  logic                    usb_dn_i,
  output usb_rx_pkg::line_state_e line_state_o,
  output logic                    sample_strobe_o,
  output logic                    bit_strobe_o
);
  import usb_rx_pkg::*;

  line_state_e line_sym;
  line_state_e line_state_q, line_state_d;
  logic [1:0]  bit_phase_q;

  // SE1 is illegal on the bus and is folded into SE0
  always_comb begin
    case ({usb_dp_i, usb_dn_i})
      2'b10:   line_sym = DJ;
      2'b01:   line_sym = DK;
      default: line_sym = SE0;
    endcase
  end

  // a change on the pair costs one DT cycle so that skew between D+ and
  // D- is never taken for a symbol, the pair is read again after it
  always_comb begin
    line_state_d = line_state_q;
    if (line_state_q == DT) begin
      line_state_d = line_sym;
    end else if (line_sym != line_state_q) begin
      line_state_d = DT;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bit clock recovery
  ////////////////////////////////////////////////////////////////////////////

  // every DT realigns the phase to the sender, phase 1 is the mid-bit
  // sample and phase 2 marks the bit for the outside world
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= SE0;
      bit_phase_q  <= 2'd0;
    end else begin
      line_state_q <= line_state_d;
      if (line_state_q == DT) begin
        bit_phase_q <= 2'd0;
      end else begin
        bit_phase_q <= bit_phase_q + 2'd1;
      end
    end
  end

  assign line_state_o    = line_state_q;
  assign sample_strobe_o = (bit_phase_q == 2'd1);
  assign bit_strobe_o    = (bit_phase_q == 2'd2);

  // a clean line settles on a new symbol after a transition, never back
  // on the one it left
  a_dt_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (line_state_q == DT) |=> (line_state_q != $past(line_state_q, 2))
  );

endmodule

//--- usb_packet_framer.sv
/*
 * Packet framer. Keeps the sampled line history, finds sync and EOP,
 * decodes NRZI and removes stuffed bits while flagging stuffing errors.
 */
`timescale 1ns/1ns

module usb_packet_framer #(
  parameter int unsigned EopSe0Bits = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  usb_rx_pkg::line_state_e line_state_i,
  input  logic                    sample_strobe_i,
  usb_rx_bit_if.framer            bit_if,
  output logic                    sop_o
);
  import usb_rx_pkg::*;

  logic [LineHistW-1:0] line_history_q;
  // the sample strobe one cycle late, when the history holds the new symbol
  logic                 decode_q;
  logic                 in_packet_q, in_packet_d;
  logic                 se0_eop;
  logic                 din, dvalid_raw;
  // the last six raw data bits, newest in bit 0
  logic [5:0]           ones_q;
  logic                 stuff_err_q;

  ////////////////////////////////////////////////////////////////////////////
  // line history and packet framing
  ////////////////////////////////////////////////////////////////////////////

  // EOP needs one or two SE0 samples depending on the build
  assign se0_eop = (EopSe0Bits == 1) ? (line_history_q[1:0] == 2'b00)
                                     : (line_history_q[3:0] == 4'b0000);

  // the packet opens on the end of sync and closes on EOP
  // a stuffing error ends it at once without waiting for the line
  always_comb begin
    in_packet_d = in_packet_q;
    if (!in_packet_q) begin
      if (decode_q && (line_history_q == SyncPattern)) begin
        in_packet_d = 1'b1;
      end
    end else if (stuff_err_q || (decode_q && se0_eop)) begin
      in_packet_d = 1'b0;
    end
  end

  // start of sync is the first J to K step on an idle bus
  assign sop_o = decode_q && !in_packet_q && (line_history_q[3:0] == 4'b10_01);

  ////////////////////////////////////////////////////////////////////////////
  // NRZI decode and bit unstuffing
  ////////////////////////////////////////////////////////////////////////////

  // no change between two symbols is a one, a change is a zero
  assign din = (line_history_q[3:2] == line_history_q[1:0]);

  // only pairs of J and K carry data, anything with SE0 or DT is dropped
  assign dvalid_raw = decode_q && in_packet_q &&
                      (line_history_q[3:0] inside {4'b0101, 4'b0110, 4'b1001, 4'b1010});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_history_q <= HistAllK;
      decode_q       <= 1'b0;
      in_packet_q    <= 1'b0;
      ones_q         <= '0;
      stuff_err_q    <= 1'b0;
    end else begin
      decode_q    <= sample_strobe_i;
      in_packet_q <= in_packet_d;
      if (sample_strobe_i) begin
        line_history_q <= {line_history_q[LineHistW-3:0], line_state_i[1:0]};
      end
      if (bit_if.pkt_start) begin
        ones_q <= '0;
      end else if (dvalid_raw) begin
        ones_q <= {ones_q[4:0], din};
      end
      // a seventh one in a row breaks the stuffing rule
      if (bit_if.pkt_start) begin
        stuff_err_q <= 1'b0;
      end else if (dvalid_raw && din && (&ones_q)) begin
        stuff_err_q <= 1'b1;
      end
    end
  end

  // the bit after six ones is the stuffed zero and never leaves the framer
  assign bit_if.bit_valid = dvalid_raw && !(&ones_q);
  assign bit_if.bit_data  = din;
  assign bit_if.pkt_start = in_packet_d && !in_packet_q;
  assign bit_if.pkt_end   = !in_packet_d && in_packet_q;
  assign bit_if.stuff_err = stuff_err_q;

  // data bits only come between the opening sync and the closing pulse
  a_bit_in_packet: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bit_if.bit_valid |-> (in_packet_q && !bit_if.pkt_end)
  );

endmodule

//--- usb_crc_check.sv
/*
 * Serial CRC5 and CRC16 checkers run side by side over the bits that
 * follow the PID, each flags a match with its good-packet residual.
 */
`timescale 1ns/1ns

module usb_crc_check (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic crc_clear_i,
  input  logic crc_bit_valid_i,
  input  logic crc_bit_i,
  output logic crc5_ok_o,
  output logic crc16_ok_o
);
  import usb_rx_pkg::*;

  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic        crc5_fb, crc16_fb;

  // feedback is the incoming bit against the register msb
  assign crc5_fb  = crc_bit_i ^ crc5_q[4];
  assign crc16_fb = crc_bit_i ^ crc16_q[15];

  // both registers only move on a payload bit and hold otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc5_q  <= Crc5Init;
      crc16_q <= Crc16Init;
    end else if (crc_clear_i) begin
      crc5_q  <= Crc5Init;
      crc16_q <= Crc16Init;
    end else if (crc_bit_valid_i) begin
      crc5_q  <= {crc5_q[3:0], 1'b0} ^ ({5{crc5_fb}} & Crc5Poly);
      crc16_q <= {crc16_q[14:0], 1'b0} ^ ({16{crc16_fb}} & Crc16Poly);
    end
  end

  // the transmitted CRC is inverted, so a good packet leaves the residual
  assign crc5_ok_o  = (crc5_q == Crc5Residual);
  assign crc16_ok_o = (crc16_q == Crc16Residual);

endmodule

//--- usb_packet_decoder.sv
/*
 * Packet decoder. Captures and checks the PID, counts the packet length,
 * pulls address and endpoint out of tokens, hands out data bytes and
 * reports the status of each packet as it ends.
 */
`timescale 1ns/1ns

module usb_packet_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  usb_rx_bit_if.decoder         bit_if,
  output usb_rx_pkg::pid_t      pid_o,
  output usb_rx_pkg::usb_addr_t addr_o,
  output usb_rx_pkg::usb_endp_t endp_o,
  output usb_rx_pkg::usb_byte_t rx_data_o,
  output logic                  rx_data_put_o,
  output logic                  valid_pid_o,
  output logic                  valid_packet_o,
  output logic                  crc5_error_o,
  output logic                  crc16_error_o,
  output logic                  pid_error_o,
  output logic                  bitstuff_error_o,
  output logic                  pkt_end_o
);
  import usb_rx_pkg::*;

  // packet class from PID bits 1:0
  typedef enum logic [1:0] {
    PktSpecial   = 2'b00,
    PktToken     = 2'b01,
    PktHandshake = 2'b10,
    PktData      = 2'b11
  } pkt_class_e;

  logic [8:0]  full_pid_q;
  logic        pid_complete, pid_valid;
  pkt_class_e  pkt_class;
  logic        pay_bit, tok_shift;
  logic        len16_q;
  logic [3:0]  len_q;
  logic [11:0] token_q, token_d;
  usb_addr_t   addr_q;
  usb_endp_t   endp_q;
  logic [8:0]  rx_buf_q, rx_buf_base;
  logic        crc5_ok, crc16_ok;

  ////////////////////////////////////////////////////////////////////////////
  // PID capture
  ////////////////////////////////////////////////////////////////////////////

  // the PID shifts in lsb first behind a sentinel that lands in bit 0
  // once all eight bits are in
  assign pid_complete = full_pid_q[0];
  assign pid_valid    = (full_pid_q[4:1] == ~full_pid_q[8:5]);
  assign pkt_class    = pkt_class_e'(full_pid_q[2:1]);

  // every bit after the PID counts toward length and CRC
  assign pay_bit   = bit_if.bit_valid && pid_complete;
  assign tok_shift = pay_bit && (pkt_class == PktToken) && !token_q[0];
  assign token_d   = {bit_if.bit_data, token_q[11:1]};

  // a finished byte restarts the buffer on the following cycle
  assign rx_buf_base = (bit_if.pkt_start || rx_buf_q[0]) ? 9'h100 : rx_buf_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_pid_q <= '0;
      len16_q    <= 1'b0;
      len_q      <= '0;
      token_q    <= '0;
      rx_buf_q   <= '0;
    end else begin
      if (bit_if.pkt_start) begin
        full_pid_q <= 9'h100;
      end else if (bit_if.bit_valid && !pid_complete) begin
        full_pid_q <= {bit_if.bit_data, full_pid_q[8:1]};
      end
      // length is kept as the low four bits plus a sticky flag for 16 or more
      if (bit_if.pkt_start) begin
        len16_q <= 1'b0;
        len_q   <= '0;
      end else if (pay_bit) begin
        len16_q <= len16_q | (&len_q);
        len_q   <= len_q + 4'd1;
      end
      // eleven token bits, address first, then endpoint
      if (bit_if.pkt_start) begin
        token_q <= 12'h800;
      end else if (tok_shift) begin
        token_q <= token_d;
      end
      if (pay_bit && (pkt_class == PktData)) begin
        rx_buf_q <= {bit_if.bit_data, rx_buf_base[8:1]};
      end else begin
        rx_buf_q <= rx_buf_base;
      end
    end
  end

  // address and endpoint are taken on the bit that completes the token
  always_ff @(posedge clk_i) begin
    if (tok_shift && token_d[0]) begin
      {endp_q, addr_q} <= token_d[11:1];
    end
  end

  usb_crc_check crc0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .crc_clear_i     (bit_if.pkt_start),
    .crc_bit_valid_i (pay_bit),
    .crc_bit_i       (bit_if.bit_data),
    .crc5_ok_o       (crc5_ok),
    .crc16_ok_o      (crc16_ok)
  );

  ////////////////////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////////////////////

  // length and CRC rules differ per class, special PIDs are never valid
  assign valid_packet_o = pid_valid && !bit_if.stuff_err &&
    (((pkt_class == PktHandshake) && !len16_q && (len_q == 4'd0)) ||
     ((pkt_class == PktToken) && len16_q && (len_q == 4'd0) && crc5_ok) ||
     ((pkt_class == PktData) && len16_q && (len_q[2:0] == 3'd0) && crc16_ok));

  assign valid_pid_o      = pid_valid;
  assign pid_o            = full_pid_q[4:1];
  assign addr_o           = addr_q;
  assign endp_o           = endp_q;
  assign rx_data_o        = rx_buf_q[8:1];
  assign rx_data_put_o    = rx_buf_q[0];
  assign pkt_end_o        = bit_if.pkt_end;
  assign crc5_error_o     = bit_if.pkt_end && (pkt_class == PktToken) && !crc5_ok;
  assign crc16_error_o    = bit_if.pkt_end && (pkt_class == PktData) && !crc16_ok;
  assign pid_error_o      = bit_if.pkt_end && !pid_valid;
  assign bitstuff_error_o = bit_if.pkt_end && bit_if.stuff_err;

  // the byte buffer and the length counter agree on every byte boundary
  a_put_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rx_data_put_o |-> (len_q[2:0] == 3'd0)
  );

endmodule

//--- usb_fs_rx.sv
/*
 * Full-speed USB packet receiver, from the D+/D- pair to decoded packets.
 */
`timescale 1ns/1ns

module usb_fs_rx #(
  parameter int unsigned EopSe0Bits = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  usb_dp_i,
  input  logic                  usb_dn_i,
  output logic                  bit_strobe_o,
  output logic                  pkt_start_o,
  output usb_rx_pkg::pid_t      pid_o,
  output usb_rx_pkg::usb_addr_t addr_o,
  output usb_rx_pkg::usb_endp_t endp_o,
  output usb_rx_pkg::usb_byte_t rx_data_o,
  output logic                  rx_data_put_o,
  output logic                  valid_pid_o,
  output logic                  valid_packet_o,
  output logic                  crc5_error_o,
  output logic                  crc16_error_o,
  output logic                  pid_error_o,
  output logic                  bitstuff_error_o,
  output logic                  pkt_end_o
);
  import usb_rx_pkg::*;

  line_state_e line_state;
  logic        sample_strobe;

  usb_rx_bit_if bit_if ();

  usb_line_recovery line0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .usb_dp_i        (usb_dp_i),
    .usb_dn_i        (usb_dn_i),
    .line_state_o    (line_state),
    .sample_strobe_o (sample_strobe),
    .bit_strobe_o    (bit_strobe_o)
  );

  // sync detection drives the top level start pulse
  usb_packet_framer #(
    .EopSe0Bits (EopSe0Bits)
  ) framer0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .line_state_i    (line_state),
    .sample_strobe_i (sample_strobe),
    .bit_if          (bit_if.framer),
    .sop_o           (pkt_start_o)
  );

  usb_packet_decoder decoder0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bit_if           (bit_if.decoder),
    .pid_o            (pid_o),
    .addr_o           (addr_o),
    .endp_o           (endp_o),
    .rx_data_o        (rx_data_o),
    .rx_data_put_o    (rx_data_put_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o),
    .pkt_end_o        (pkt_end_o)
  );

endmodule

//--- usb_host_model.sv
/*
 * USB host model for the receiver testbench. Each send request puts one
 * packet on D+/D- with sync, bit stuffing, NRZI coding and an SE0 EOP.
 */
`timescale 1ns/1ns

module usb_host_model (
  input  logic                  clk_i,
  input  logic                  send_i,
  input  usb_rx_pkg::pid_t      pid_i,
  input  usb_rx_pkg::usb_addr_t addr_i,
  input  usb_rx_pkg::usb_endp_t endp_i,
  input  logic [31:0]           data_i,
  input  logic                  bad_pid_i,
  input  logic                  bad_crc_i,
  input  logic                  no_stuff_i,
  output logic                  dp_o,
  output logic                  dn_o,
  output logic                  done_o
);
  import usb_rx_pkg::*;

  // NRZI line level, high while the bus sits at J
  logic level_j;
  int   ones;
  // unstuffed packet bits from the PID onwards, in wire order
  logic raw_bits[$];

  // one symbol lasts four receiver clocks
  task automatic drive_symbol(input logic dp, input logic dn);
    @(posedge clk_i);
    dp_o <= dp;
    dn_o <= dn;
    repeat (3) @(posedge clk_i);
  endtask

  // a zero toggles the line, a one leaves it where it is
  task automatic send_nrzi(input logic b);
    if (!b) begin
      level_j = !level_j;
    end
    drive_symbol(level_j, !level_j);
  endtask

  // serial CRC over the bits in wire order, starting from all ones
  function automatic logic [4:0] crc5_of(input logic [10:0] bits);
    logic [4:0] crc;
    logic       fb;
    crc = Crc5Init;
    for (int i = 0; i < 11; i++) begin
      fb  = bits[i] ^ crc[4];
      crc = {crc[3:0], 1'b0} ^ (fb ? Crc5Poly : 5'b00000);
    end
    return crc;
  endfunction

  function automatic logic [15:0] crc16_of(input logic [31:0] bits);
    logic [15:0] crc;
    logic        fb;
    crc = Crc16Init;
    for (int i = 0; i < 32; i++) begin
      fb  = bits[i] ^ crc[15];
      crc = {crc[14:0], 1'b0} ^ (fb ? Crc16Poly : 16'h0000);
    end
    return crc;
  endfunction

  // PID with its check nibble, then the fields that PID bits 1:0 call for
  // the CRC goes out inverted and msb first
  task automatic build_packet();
    logic [3:0]  check;
    logic [4:0]  crc5;
    logic [15:0] crc16;
    raw_bits.delete();
    check = ~pid_i ^ {3'b000, bad_pid_i};
    for (int i = 0; i < 4; i++) raw_bits.push_back(pid_i[i]);
    for (int i = 0; i < 4; i++) raw_bits.push_back(check[i]);
    if (pid_i[1:0] == 2'b01) begin
      crc5 = ~crc5_of({endp_i, addr_i}) ^ {4'b0000, bad_crc_i};
      for (int i = 0; i < 7; i++) raw_bits.push_back(addr_i[i]);
      for (int i = 0; i < 4; i++) raw_bits.push_back(endp_i[i]);
      for (int i = 4; i >= 0; i--) raw_bits.push_back(crc5[i]);
    end else if (pid_i[1:0] == 2'b11) begin
      crc16 = ~crc16_of(data_i) ^ {15'h0000, bad_crc_i};
      for (int i = 0; i < 32; i++) raw_bits.push_back(data_i[i]);
      for (int i = 15; i >= 0; i--) raw_bits.push_back(crc16[i]);
    end
  endtask

  initial begin
    dp_o    <= 1'b1;
    dn_o    <= 1'b0;
    done_o  <= 1'b0;
    level_j = 1'b1;
    forever begin
      @(posedge clk_i);
      if (send_i) begin
        build_packet();
        repeat (4) drive_symbol(1'b1, 1'b0);
        // sync is seven zeros and a one, K J K J K J K K on the wire
        level_j = 1'b1;
        repeat (7) send_nrzi(1'b0);
        send_nrzi(1'b1);
        ones = 0;
        foreach (raw_bits[i]) begin
          send_nrzi(raw_bits[i]);
          ones = raw_bits[i] ? ones + 1 : 0;
          if ((ones == 6) && !no_stuff_i) begin
            send_nrzi(1'b0);
            ones = 0;
          end
        end
        // EOP is two SE0 bits and a J
        drive_symbol(1'b0, 1'b0);
        drive_symbol(1'b0, 1'b0);
        drive_symbol(1'b1, 1'b0);
        level_j = 1'b1;
        @(posedge clk_i);
        done_o <= 1'b1;
        @(posedge clk_i);
        done_o <= 1'b0;
      end
    end
  end

endmodule

//--- tb_usb_fs_rx.sv
/*
 * Testbench for the full-speed USB receiver. A host model sends tokens,
 * data and handshake packets, some of them damaged on purpose, and
 * assertions check the status that the DUT reports as each packet ends.
 */
`timescale 1ns/1ns

module tb_usb_fs_rx;
  import usb_rx_pkg::*;

  // a packet takes a few hundred clocks, this bound is generous
  localparam int WaitLimit = 2000;

  logic        clk, rst_n;
  logic        usb_dp, usb_dn;
  logic        bit_strobe, pkt_start, pkt_end, rx_data_put;
  pid_t        dut_pid;
  usb_addr_t   rx_addr;
  usb_endp_t   rx_endp;
  usb_byte_t   rx_data;
  logic        valid_pid, valid_packet;
  logic        crc5_error, crc16_error, pid_error, bitstuff_error;
  logic        send, bad_pid, bad_crc, no_stuff, host_done;
  pid_t        tx_pid;
  usb_addr_t   tx_addr;
  usb_endp_t   tx_endp;
  logic [31:0] tx_data;
  logic        start_seen;
  usb_byte_t   rx_bytes[$];
  integer      seed = 16;
  int          checks = 0;
  int          mismatches = 0;
  int          assert_fails = 0;
  int          timeouts = 0;

  usb_fs_rx #(.EopSe0Bits(2)) dut0 (
    .clk_i (clk), .rst_ni (rst_n), .usb_dp_i (usb_dp), .usb_dn_i (usb_dn),
    .bit_strobe_o (bit_strobe), .pkt_start_o (pkt_start), .pid_o (dut_pid),
    .addr_o (rx_addr), .endp_o (rx_endp), .rx_data_o (rx_data),
    .rx_data_put_o (rx_data_put), .valid_pid_o (valid_pid),
    .valid_packet_o (valid_packet), .crc5_error_o (crc5_error),
    .crc16_error_o (crc16_error), .pid_error_o (pid_error),
    .bitstuff_error_o (bitstuff_error), .pkt_end_o (pkt_end)
  );

  usb_host_model host0 (
    .clk_i (clk), .send_i (send), .pid_i (tx_pid), .addr_i (tx_addr),
    .endp_i (tx_endp), .data_i (tx_data), .bad_pid_i (bad_pid),
    .bad_crc_i (bad_crc), .no_stuff_i (no_stuff), .dp_o (usb_dp),
    .dn_o (usb_dn), .done_o (host_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = !clk;
  end

  // every byte handed out is kept, tests look at the tail they caused
  always @(posedge clk) begin
    if (rx_data_put) rx_bytes.push_back(rx_data);
    if (!rst_n) begin
      start_seen <= 1'b0;
    end else if (pkt_start) begin
      start_seen <= 1'b1;
    end else if (pkt_end) begin
      start_seen <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol assertions
  ////////////////////////////////////////////////////////////////////////////

  a_start_before_end: assert property (
    @(posedge clk) disable iff (!rst_n) pkt_end |-> start_seen
  ) else begin
    assert_fails++;
    $display("pkt_end_o at %0t ns came without a pkt_start_o before it", $time);
  end

  a_error_with_end: assert property (
    @(posedge clk) disable iff (!rst_n)
    (crc5_error || crc16_error || pid_error || bitstuff_error) |-> pkt_end
  ) else begin
    assert_fails++;
    $display("an error pulse at %0t ns came without pkt_end_o", $time);
  end

  // a change on the pair realigns the bit clock, its strobe marks mid-bit
  a_strobe_after_change: assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed({usb_dp, usb_dn}) |-> ##4 bit_strobe
  ) else begin
    assert_fails++;
    $display("bit_strobe_o at %0t ns missed the mid-bit after a line change", $time);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
             checks, mismatches, assert_fails, timeouts);
    if ((mismatches == 0) && (assert_fails == 0) && (timeouts == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic send_packet(input pid_t p, input usb_addr_t a, input usb_endp_t e,
                             input logic [31:0] d, input logic bp, input logic bc,
                             input logic ns);
    @(posedge clk);
    tx_pid   <= p;
    tx_addr  <= a;
    tx_endp  <= e;
    tx_data  <= d;
    bad_pid  <= bp;
    bad_crc  <= bc;
    no_stuff <= ns;
    send     <= 1'b1;
    @(posedge clk);
    send <= 1'b0;
  endtask

  // looks on the falling edge, so outputs still hold the values of the
  // cycle the signal was high in
  task automatic wait_for_signal(input bit host_side, input string what);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < WaitLimit)) begin
      @(negedge clk);
      seen = host_side ? host_done : pkt_end;
      n++;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout at %0t ns while waiting for %s", $time, what);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    usb_addr_t   exp_addr;
    usb_endp_t   exp_endp;
    logic [31:0] exp_data;
    int          base;
    rst_n    <= 1'b0;
    send     <= 1'b0;
    tx_pid   <= '0;
    tx_addr  <= '0;
    tx_endp  <= '0;
    tx_data  <= '0;
    bad_pid  <= 1'b0;
    bad_crc  <= 1'b0;
    no_stuff <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);

    // OUT token with a random address and endpoint
    rnd      = $random(seed);
    exp_addr = rnd[6:0];
    exp_endp = rnd[11:8];
    send_packet(UsbPidOut, exp_addr, exp_endp, 32'h0, 1'b0, 1'b0, 1'b0);
    wait_for_signal(1'b0, "pkt_end_o of the OUT token");
    check_value("valid_packet_o", 32'(valid_packet), 32'd1);
    check_value("valid_pid_o", 32'(valid_pid), 32'd1);
    check_value("crc5_error_o", 32'(crc5_error), 32'd0);
    check_value("pid_o", 32'(dut_pid), 32'(UsbPidOut));
    check_value("addr_o", 32'(rx_addr), 32'(exp_addr));
    check_value("endp_o", 32'(rx_endp), 32'(exp_endp));
    wait_for_signal(1'b1, "the host after the OUT token");

    // DATA0 with four random bytes, then two CRC bytes come out as well
    exp_data = $random(seed);
    base     = rx_bytes.size();
    send_packet(UsbPidData0, '0, '0, exp_data, 1'b0, 1'b0, 1'b0);
    wait_for_signal(1'b0, "pkt_end_o of the DATA0 packet");
    check_value("valid_packet_o", 32'(valid_packet), 32'd1);
    wait_for_signal(1'b1, "the host after the DATA0 packet");
    check_value("rx_data_put_o count", rx_bytes.size() - base, 32'd6);
    for (int i = 0; i < 4; i++) begin
      if (base + i < rx_bytes.size()) begin
        check_value("rx_data_o", 32'(rx_bytes[base + i]), 32'(exp_data[8*i +: 8]));
      end
    end

    // same data with one CRC bit flipped
    send_packet(UsbPidData0, '0, '0, exp_data, 1'b0, 1'b1, 1'b0);
    wait_for_signal(1'b0, "pkt_end_o of the bad CRC packet");
    check_value("crc16_error_o", 32'(crc16_error), 32'd1);
    check_value("valid_packet_o", 32'(valid_packet), 32'd0);
    wait_for_signal(1'b1, "the host after the bad CRC packet");

    // token whose check nibble is not the inverse of the PID
    send_packet(UsbPidOut, exp_addr, exp_endp, 32'h0, 1'b1, 1'b0, 1'b0);
    wait_for_signal(1'b0, "pkt_end_o of the bad PID token");
    check_value("pid_error_o", 32'(pid_error), 32'd1);
    check_value("valid_pid_o", 32'(valid_pid), 32'd0);
    wait_for_signal(1'b1, "the host after the bad PID token");

    // eight ones at the front of the payload, sent without stuffing
    send_packet(UsbPidData0, '0, '0, 32'h5A5A_A5FF, 1'b0, 1'b0, 1'b1);
    wait_for_signal(1'b0, "pkt_end_o of the unstuffed packet");
    check_value("bitstuff_error_o", 32'(bitstuff_error), 32'd1);
    check_value("valid_packet_o", 32'(valid_packet), 32'd0);
    wait_for_signal(1'b1, "the host after the unstuffed packet");

    // ACK handshake, no payload bytes at all
    base = rx_bytes.size();
    send_packet(UsbPidAck, '0, '0, 32'h0, 1'b0, 1'b0, 1'b0);
    wait_for_signal(1'b0, "pkt_end_o of the ACK handshake");
    check_value("valid_packet_o", 32'(valid_packet), 32'd1);
    check_value("pid_o", 32'(dut_pid), 32'(UsbPidAck));
    wait_for_signal(1'b1, "the host after the ACK handshake");
    check_value("rx_data_put_o count", rx_bytes.size() - base, 32'd0);

    finish_run();
  end

endmodule

//--- vlog.f
usb_rx_pkg.sv
usb_rx_bit_if.sv
usb_line_recovery.sv
usb_packet_framer.sv
usb_crc_check.sv
usb_packet_decoder.sv
usb_fs_rx.sv
usb_host_model.sv
tb_usb_fs_rx.sv

//--- run.sh
#!/bin/sh
# Build and run the USB receiver testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_usb_fs_rx -f vlog.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0
